/* rtl/corePkg.sv */
// Execution core shared types
`default_nettype none

package corePkg;

  localparam int dataWidth   = 32;
  localparam int regCount    = 8;
  localparam int regIdxWidth = 3;
  localparam int shiftWidth  = 5;

  // ALU control codes
  typedef enum logic [4:0] {
    opAdd  = 5'd3,
    opSub  = 5'd4,
    opAnd  = 5'd5,
    opShr  = 5'd7,
    opShra = 5'd8,
    opShl  = 5'd9,
    opRor  = 5'd10,
    opRol  = 5'd11,
    opMul  = 5'd15,
    opNeg  = 5'd17,
    opNot  = 5'd18
  } aluOp;

  typedef struct packed {
    aluOp                   op;
    logic [regIdxWidth-1:0] ra;    // destination
    logic [regIdxWidth-1:0] rb;    // goes to Y
    logic [regIdxWidth-1:0] rc;    // second operand on the bus
  } instrWord;

  typedef enum logic [1:0] {
    stIdle,
    stLoadY,     // T3
    stCompute,   // T4
    stWrite      // T5
  } stepState;

  typedef struct packed {
    logic [regIdxWidth-1:0] busSel;
    logic                   yLoad;
    logic                   zLoad;
    logic                   regWrite;
    logic [regIdxWidth-1:0] writeSel;
    logic                   fromLoad;  // write external data instead of Z low
    aluOp                   op;
  } ctrlBundle;

  typedef struct packed {
    logic [dataWidth-1:0] lo;
    logic [dataWidth-1:0] hi;
  } unitResult;

  typedef struct packed {
    logic [regIdxWidth-1:0] dest;
    logic [dataWidth-1:0]   lo;
    logic [dataWidth-1:0]   hi;
  } doneResult;

endpackage

`default_nettype wire

/* rtl/busRegisters.sv */
// General registers and Y latch
`timescale 1ns/1ps
`default_nettype none

module busRegisters (
  input  wire logic                         clock,
  input  wire logic                         arstN,
  input  wire corePkg::ctrlBundle           ctrl,
  input  wire logic [corePkg::dataWidth-1:0] loadData,
  input  wire logic [corePkg::dataWidth-1:0] zLo,
  output logic      [corePkg::dataWidth-1:0] busValue,
  output logic      [corePkg::dataWidth-1:0] yValue
);

  logic [corePkg::dataWidth-1:0] regFile [corePkg::regCount];
  logic [corePkg::dataWidth-1:0] yReg;
  logic [corePkg::dataWidth-1:0] writeData;

  assign writeData = ctrl.fromLoad ? loadData : zLo;  // load port or T5 writeback

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < corePkg::regCount; i++) begin
        regFile[i] <= '0;
      end
    end else if (ctrl.regWrite) begin
      regFile[ctrl.writeSel] <= writeData;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      yReg <= '0;
    end else if (ctrl.yLoad) begin
      yReg <= busValue;  // Y sees the bus, same as the reference datapath
    end
  end

  assign busValue = regFile[ctrl.busSel];
  assign yValue   = yReg;

endmodule

`default_nettype wire

/* rtl/controlSequencer.sv */
// Instruction step sequencer
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
  input  wire logic                             clock,
  input  wire logic                             arstN,
  input  wire logic                             instStrobe,
  input  wire corePkg::instrWord                instr,
  input  wire logic                             loadStrobe,
  input  wire logic [corePkg::regIdxWidth-1:0]  loadIdx,
  output corePkg::ctrlBundle                    ctrl,
  output logic                                  busy,
  output logic                                  done,
  output logic      [corePkg::regIdxWidth-1:0]  doneDest
);

  corePkg::stepState state;
  corePkg::stepState nextState;
  corePkg::instrWord heldInstr;

  always_comb begin
    nextState = state;
    case (state)
      corePkg::stIdle:    if (instStrobe) nextState = corePkg::stLoadY;
      corePkg::stLoadY:   nextState = corePkg::stCompute;
      corePkg::stCompute: nextState = corePkg::stWrite;
      default:            nextState = corePkg::stIdle;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state <= corePkg::stIdle;
      done  <= 1'b0;
    end else begin
      state <= nextState;
      done  <= (state == corePkg::stWrite);  // one cycle after the write edge
    end
  end

  always_ff @(posedge clock) begin
    if (state == corePkg::stIdle && instStrobe) begin
      heldInstr <= instr;
    end
    if (state == corePkg::stWrite) begin
      doneDest <= heldInstr.ra;
    end
  end

  // per-step controls, T3 to T5
  always_comb begin
    ctrl        = '0;
    ctrl.op     = heldInstr.op;
    ctrl.busSel = heldInstr.rb;
    case (state)
      corePkg::stIdle: begin
        if (loadStrobe) begin
          ctrl.regWrite = 1'b1;
          ctrl.writeSel = loadIdx;
          ctrl.fromLoad = 1'b1;
        end
      end
      corePkg::stLoadY: begin
        ctrl.busSel = heldInstr.rb;
        ctrl.yLoad  = 1'b1;
      end
      corePkg::stCompute: begin
        ctrl.busSel = heldInstr.rc;
        ctrl.zLoad  = 1'b1;
      end
      default: begin
        ctrl.regWrite = 1'b1;  // Z low into ra
        ctrl.writeSel = heldInstr.ra;
      end
    endcase
  end

  assign busy = (state != corePkg::stIdle);

  // strobes are only legal while idle, there is no stall
  assertNoStrobeWhileBusy: assert property (
    @(posedge clock) disable iff (!arstN) busy |-> !(instStrobe || loadStrobe)
  );

  // fixed latency, done is seen four edges after the accepted strobe
  assertDoneLatency: assert property (
    @(posedge clock) disable iff (!arstN) (instStrobe && !busy) |-> ##4 done
  );

endmodule

`default_nettype wire

/* rtl/logicShiftUnit.sv */
// Logic and shift unit
`timescale 1ns/1ps
`default_nettype none

module logicShiftUnit (
  input  wire corePkg::aluOp                    op,
  input  wire logic [corePkg::dataWidth-1:0]    yValue,
  input  wire logic [corePkg::dataWidth-1:0]    busValue,
  output corePkg::unitResult                    res
);

  logic [corePkg::shiftWidth-1:0]  amount;
  logic [2*corePkg::dataWidth-1:0] yDouble;
  logic [2*corePkg::dataWidth-1:0] rorWide;
  logic [2*corePkg::dataWidth-1:0] rolWide;

  assign amount  = busValue[corePkg::shiftWidth-1:0];  // count from the low bus bits
  assign yDouble = {yValue, yValue};
  assign rorWide = yDouble >> amount;
  assign rolWide = yDouble << amount;

  always_comb begin
    res.hi = '0;
    case (op)
      corePkg::opAnd:  res.lo = yValue & busValue;
      corePkg::opNot:  res.lo = ~yValue;  // bus unused
      corePkg::opShr:  res.lo = yValue >> amount;
      corePkg::opShra: res.lo = $signed(yValue) >>> amount;
      corePkg::opShl:  res.lo = yValue << amount;
      corePkg::opRor:  res.lo = rorWide[corePkg::dataWidth-1:0];
      corePkg::opRol:  res.lo = rolWide[2*corePkg::dataWidth-1:corePkg::dataWidth];
      default:         res.lo = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/arithmeticUnit.sv */
// Add, subtract, negate, multiply
`timescale 1ns/1ps
`default_nettype none

module arithmeticUnit (
  input  wire corePkg::aluOp                    op,
  input  wire logic [corePkg::dataWidth-1:0]    yValue,
  input  wire logic [corePkg::dataWidth-1:0]    busValue,
  output corePkg::unitResult                    res
);

  logic signed [2*corePkg::dataWidth-1:0] product;

  // signed operands widen to 64 bits before the multiply
  assign product = $signed(yValue) * $signed(busValue);

  always_comb begin
    res.hi = '0;
    case (op)
      corePkg::opAdd: res.lo = yValue + busValue;
      corePkg::opSub: res.lo = yValue - busValue;  // Y minus bus
      corePkg::opNeg: res.lo = '0 - yValue;
      corePkg::opMul: begin
        res.lo = product[corePkg::dataWidth-1:0];
        res.hi = product[2*corePkg::dataWidth-1:corePkg::dataWidth];
      end
      default:        res.lo = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/resultStage.sv */
// Z and HI registers
`timescale 1ns/1ps
`default_nettype none

module resultStage (
  input  wire logic                             clock,
  input  wire logic                             arstN,
  input  wire corePkg::ctrlBundle               ctrl,
  input  wire corePkg::unitResult               logicRes,
  input  wire corePkg::unitResult               arithRes,
  input  wire logic                             done,
  input  wire logic [corePkg::regIdxWidth-1:0]  doneDest,
  output logic      [corePkg::dataWidth-1:0]    zLo,
  output corePkg::doneResult                    result
);

  corePkg::unitResult selRes;
  corePkg::unitResult zReg;
  logic [corePkg::dataWidth-1:0] hiReg;

  always_comb begin
    case (ctrl.op)
      corePkg::opAdd, corePkg::opSub, corePkg::opNeg, corePkg::opMul: selRes = arithRes;
      default: selRes = logicRes;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      zReg  <= '0;
      hiReg <= '0;
    end else begin
      if (ctrl.zLoad) begin
        zReg <= selRes;
      end
      if (ctrl.regWrite && !ctrl.fromLoad) begin
        hiReg <= zReg.hi;  // HI follows the T5 writeback
      end
    end
  end

  assign zLo         = zReg.lo;
  assign result.dest = doneDest;
  assign result.lo   = zReg.lo;  // Z holds through the done cycle
  assign result.hi   = hiReg;

  assertZLoadDefinedOp: assert property (
    @(posedge clock) disable iff (!arstN)
    ctrl.zLoad |-> ctrl.op inside {corePkg::opAdd, corePkg::opSub, corePkg::opAnd,
                                   corePkg::opShr, corePkg::opShra, corePkg::opShl,
                                   corePkg::opRor, corePkg::opRol, corePkg::opMul,
                                   corePkg::opNeg, corePkg::opNot}
  );

  // done only follows a Z writeback
  assertDoneAfterWrite: assert property (
    @(posedge clock) disable iff (!arstN)
    done |-> $past(ctrl.regWrite && !ctrl.fromLoad)
  );

endmodule

`default_nettype wire

/* rtl/busCpuCore.sv */
// Bus execution core top
`timescale 1ns/1ps
`default_nettype none

module busCpuCore (
  input  wire logic                             clock,
  input  wire logic                             arstN,
  input  wire logic                             loadStrobe,
  input  wire logic [corePkg::regIdxWidth-1:0]  loadIdx,
  input  wire logic [corePkg::dataWidth-1:0]    loadData,
  input  wire logic                             instStrobe,
  input  wire corePkg::instrWord                instr,
  output logic                                  done,
  output corePkg::doneResult                    result,
  output logic                                  busy
);

  corePkg::ctrlBundle            ctrl;
  corePkg::unitResult            logicRes;
  corePkg::unitResult            arithRes;
  logic [corePkg::dataWidth-1:0]   busValue;
  logic [corePkg::dataWidth-1:0]   yValue;
  logic [corePkg::dataWidth-1:0]   zLo;
  logic [corePkg::regIdxWidth-1:0] doneDest;

  controlSequencer u_controlSequencer (
    .clock      (clock),
    .arstN      (arstN),
    .instStrobe (instStrobe),
    .instr      (instr),
    .loadStrobe (loadStrobe),
    .loadIdx    (loadIdx),
    .ctrl       (ctrl),
    .busy       (busy),
    .done       (done),
    .doneDest   (doneDest)
  );

  busRegisters u_busRegisters (
    .clock    (clock),
    .arstN    (arstN),
    .ctrl     (ctrl),
    .loadData (loadData),
    .zLo      (zLo),
    .busValue (busValue),
    .yValue   (yValue)
  );

  logicShiftUnit u_logicShiftUnit (
    .op       (ctrl.op),
    .yValue   (yValue),
    .busValue (busValue),
    .res      (logicRes)
  );

  arithmeticUnit u_arithmeticUnit (
    .op       (ctrl.op),
    .yValue   (yValue),
    .busValue (busValue),
    .res      (arithRes)
  );

  resultStage u_resultStage (
    .clock    (clock),
    .arstN    (arstN),
    .ctrl     (ctrl),
    .logicRes (logicRes),
    .arithRes (arithRes),
    .done     (done),
    .doneDest (doneDest),
    .zLo      (zLo),
    .result   (result)
  );

endmodule

`default_nettype wire

/* dv/coreTb.sv */
// Execution core testbench
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  localparam int maxCases      = 64;
  localparam int caseWordCount = 4 * maxCases;  // header, data, lo, hi per case
  localparam int doneWait      = 4;             // negedges from the strobe edge to done

  logic                            clock;
  logic                            arstN;
  logic                            loadStrobe;
  logic [corePkg::regIdxWidth-1:0] loadIdx;
  logic [corePkg::dataWidth-1:0]   loadData;
  logic                            instStrobe;
  corePkg::instrWord               instr;
  logic                            done;
  corePkg::doneResult              result;
  logic                            busy;

  logic [31:0] caseMem [caseWordCount];
  int          caseCount;
  int          errorCount;
  int          checkCount;
  logic        casesReady;

  busCpuCore u_busCpuCore (
    .clock      (clock),
    .arstN      (arstN),
    .loadStrobe (loadStrobe),
    .loadIdx    (loadIdx),
    .loadData   (loadData),
    .instStrobe (instStrobe),
    .instr      (instr),
    .done       (done),
    .result     (result),
    .busy       (busy)
  );

  always #5 clock = ~clock;

  task automatic readCases();
    for (int i = 0; i < caseWordCount; i++) begin
      caseMem[i] = '0;
    end
    $readmemh("dv/aluCases.txt", caseMem);
    caseCount = 0;
    while (caseCount < maxCases && caseMem[4*caseCount][31:28] != 4'h0) begin
      caseCount++;  // kind 0 marks the end
    end
    if (caseCount == 0) begin
      errorCount++;
      $display("No cases could be read from dv/aluCases.txt");
    end
  endtask

  task automatic applyLoad(input logic [31:0] header, input logic [31:0] data);
    @(posedge clock);
    loadStrobe <= 1'b1;
    loadIdx    <= header[14:12];
    loadData   <= data;
    @(posedge clock);
    loadStrobe <= 1'b0;
  endtask

  task automatic runInstruction(input int idx, input logic [31:0] header,
                                input logic [31:0] expLo, input logic [31:0] expHi);
    corePkg::instrWord word;
    corePkg::aluOp     opCode;
    string             name;
    int                waited;
    opCode  = corePkg::aluOp'(header[20:16]);
    word.op = opCode;
    word.ra = header[14:12];
    word.rb = header[10:8];
    word.rc = header[6:4];
    name    = $sformatf("case%0d_%s", idx, opCode.name());
    @(posedge clock);
    instStrobe <= 1'b1;
    instr      <= word;
    @(posedge clock);
    instStrobe <= 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!done);  // watchdog covers a missing done
    checkCount += 5;
    if (waited != doneWait) begin
      errorCount++;
      $display("CHECK FAILED %s latency expected %0d actual %0d", name, doneWait, waited);
    end
    if (result.dest !== word.ra) begin
      errorCount++;
      $display("CHECK FAILED %s dest expected %0d actual %0d", name, word.ra, result.dest);
    end
    if (result.lo !== expLo) begin
      errorCount++;
      $display("CHECK FAILED %s lo expected 0x%08h actual 0x%08h", name, expLo, result.lo);
    end
    if (result.hi !== expHi) begin
      errorCount++;
      $display("CHECK FAILED %s hi expected 0x%08h actual 0x%08h", name, expHi, result.hi);
    end
    if (busy !== 1'b0) begin
      errorCount++;
      $display("CHECK FAILED %s busy expected 0 actual %0b", name, busy);
    end
  endtask

  initial begin
    logic [31:0] header;
    int          gap;
    clock      = 1'b0;
    arstN      = 1'b0;
    loadStrobe = 1'b0;
    loadIdx    = '0;
    loadData   = '0;
    instStrobe = 1'b0;
    instr      = '0;
    errorCount = 0;
    checkCount = 0;
    casesReady = 1'b0;
    void'($urandom(32'h8463));
    readCases();
    casesReady = 1'b1;
    repeat (3) @(posedge clock);
    arstN <= 1'b1;
    @(negedge clock);
    checkCount++;
    if (busy !== 1'b0 || done !== 1'b0 || result.lo !== '0 || result.hi !== '0) begin
      errorCount++;
      $display("CHECK FAILED reset busy/done/lo/hi expected 0/0/0/0 actual %0b/%0b/%08h/%08h",
               busy, done, result.lo, result.hi);
    end
    for (int i = 0; i < caseCount; i++) begin
      header = caseMem[4*i];
      gap    = $urandom_range(3, 0);  // idle gap between cases
      repeat (gap) @(posedge clock);
      if (header[31:28] == 4'h1) begin
        applyLoad(header, caseMem[4*i+1]);
      end else begin
        runInstruction(i, header, caseMem[4*i+2], caseMem[4*i+3]);
      end
    end
    repeat (2) @(posedge clock);
    $display("Closing: %0d errors in %0d checks over %0d cases", errorCount, checkCount,
             caseCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // each case takes well under ten cycles
  initial begin
    wait (casesReady);
    repeat (caseCount * 10 + 50) @(posedge clock);
    $display("Timeout: the cases did not finish within %0d cycles", caseCount * 10 + 50);
    $display("Closing: %0d errors in %0d checks, run stopped", errorCount + 1, checkCount);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/aluCases.txt */
// columns: header, load data, expected lo, expected hi
// header hex digits K 0 OO A B C 0: kind (1 load, 2 instr), opcode, ra or load index, rb, rc
// reference preloads
10002000 00000005 00000000 00000000
10003000 00000002 00000000 00000000
10004000 00000018 00000000 00000000
10005000 00000018 00000000 00000000
10006000 00000001 00000000 00000000
10007000 00000005 00000000 00000000
10001000 00000002 00000000 00000000
// read back through add with R0
20031100 00000000 00000002 00000000
20032200 00000000 00000005 00000000
20033300 00000000 00000002 00000000
20034400 00000000 00000018 00000000
20035500 00000000 00000018 00000000
20036600 00000000 00000001 00000000
20037700 00000000 00000005 00000000
// and, add, sub
10006000 F0F0A5A5 00000000 00000000
10007000 0FF0FF00 00000000 00000000
20051670 00000000 00F0A500 00000000
20035340 00000000 0000001A 00000000
20032670 00000000 00E1A4A5 00000000
20043540 00000000 00000002 00000000
20044350 00000000 FFFFFFE8 00000000
// mul, 5 by 2 and -24 by 0x0FF0FF00
10005000 00000005 00000000 00000000
200F1530 00000000 0000000A 00000000
200F2470 00000000 81681800 FFFFFFFE
// shifts, count 0x24 keeps only 4
10005000 00000024 00000000 00000000
20071650 00000000 0F0F0A5A 00000000
20082650 00000000 FF0F0A5A 00000000
20093650 00000000 0F0A5A50 00000000
20084750 00000000 00FF0FF0 00000000
// rotates by 8 and by zero
10005000 00000008 00000000 00000000
200A1650 00000000 A5F0F0A5 00000000
200B2650 00000000 F0A5A5F0 00000000
200A3600 00000000 F0F0A5A5 00000000
200B4700 00000000 0FF0FF00 00000000
// neg and not
20115600 00000000 0F0F5A5B 00000000
20121700 00000000 F00F00FF 00000000
20112000 00000000 00000000 00000000
20123000 00000000 FFFFFFFF 00000000

/* all.f */
rtl/corePkg.sv
rtl/busRegisters.sv
rtl/controlSequencer.sv
rtl/logicShiftUnit.sv
rtl/arithmeticUnit.sv
rtl/resultStage.sv
rtl/busCpuCore.sv
dv/coreTb.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module coreTb -Mdir obj_dir -o coreTb

run: compile
	./obj_dir/coreTb > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
